// File: include/dmem_consts.svh
`ifndef DMEM_CONSTS_SVH
`define DMEM_CONSTS_SVH

// Data memory geometry
`define DMEM_BYTES 4096                 // Byte-addressed, power of two
`define DMEM_AW $clog2(`DMEM_BYTES)     // Address bits kept, upper bits wrap

// Core data path
`define XLEN 32                         // Register and bus width
`define XLEN_BYTES (`XLEN / 8)          // Byte lanes per word

// Commit path queues
`define CQ_DEPTH 4                      // Entries in each commit queue

`endif

// File: hw/dmem_pkg.sv
`include "dmem_consts.svh"

package dmem_pkg;

    // RISC-V funct3 encodings for loads and stores
    typedef enum logic [2:0] {
        MEM_B  = 3'b000,                // LB / SB
        MEM_H  = 3'b001,                // LH / SH
        MEM_W  = 3'b010,                // LW / SW
        MEM_BU = 3'b100,                // LBU, load only
        MEM_HU = 3'b101                 // LHU, load only
    } mem_size_e;

    // One word seen as byte lanes, lane 0 at the lowest address
    typedef logic [`XLEN_BYTES-1:0][7:0] lanes_t;

    // Speculative load from the load/store unit
    typedef struct packed {
        logic              valid;
        mem_size_e         funct3;
        logic [`XLEN-1:0]  address;
    } load_req_t;

    typedef struct packed {
        logic              valid;       // One-cycle pulse
        logic [`XLEN-1:0]  data;        // Extended load result
    } load_resp_t;

    // Retired memory op from the reorder buffer
    typedef struct packed {
        logic              is_store;
        mem_size_e         funct3;
        logic [`XLEN-1:0]  address;
        logic [`XLEN-1:0]  value;       // Store data, or the speculative load value
    } commit_req_t;

    typedef struct packed {
        logic              is_store;
        logic              exception;   // Load value changed since speculation
    } commit_resp_t;

endpackage

// File: hw/mem_align.sv
`timescale 1ns/100ps
`include "dmem_consts.svh"

module mem_align import dmem_pkg::*; (
    input  mem_size_e                funct3,
    input  logic [`XLEN-1:0]         raw,        // Four bytes from the access address up
    input  logic [`XLEN-1:0]         store_data,
    output logic [`XLEN-1:0]         load_data,
    output logic [`XLEN_BYTES-1:0]   wbe,
    output logic [`XLEN-1:0]         wdata
);

    // Load side, all five load formats
    always_comb begin
        case (funct3)
            MEM_B:   load_data = {{(`XLEN-8){raw[7]}}, raw[7:0]};
            MEM_H:   load_data = {{(`XLEN-16){raw[15]}}, raw[15:0]};
            MEM_W:   load_data = raw;
            MEM_BU:  load_data = {{(`XLEN-8){1'b0}}, raw[7:0]};
            MEM_HU:  load_data = {{(`XLEN-16){1'b0}}, raw[15:0]};
            default: load_data = '0;              // Unknown code reads as zero
        endcase
    end

    // Store side, only SB, SH and SW exist
    always_comb begin
        case (funct3)
            MEM_B: begin
                wbe   = `XLEN_BYTES'(4'b0001);
                wdata = {{(`XLEN-8){1'b0}}, store_data[7:0]};
            end
            MEM_H: begin
                wbe   = `XLEN_BYTES'(4'b0011);
                wdata = {{(`XLEN-16){1'b0}}, store_data[15:0]};
            end
            MEM_W: begin
                wbe   = '1;
                wdata = store_data;
            end
            default: begin
                wbe   = '0;                       // Nothing written
                wdata = '0;
            end
        endcase
    end

endmodule

// File: hw/byte_ram.sv
`timescale 1ns/100ps
`include "dmem_consts.svh"

module byte_ram import dmem_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [`DMEM_AW-1:0]      raddr_a,    // Speculative load port
    input  logic [`DMEM_AW-1:0]      raddr_b,    // Commit port
    output lanes_t                   rdata_a,
    output lanes_t                   rdata_b,
    input  logic [`DMEM_AW-1:0]      waddr,
    input  logic [`XLEN-1:0]         wdata,
    input  logic [`XLEN_BYTES-1:0]   wbe
);

    localparam int AW    = `DMEM_AW;
    localparam int LANES = `XLEN_BYTES;

    logic [7:0] mem [`DMEM_BYTES];

    // Both reads are combinational, so a same-edge write is not seen
    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            rdata_a[k] = mem[raddr_a + AW'(k)];   // Sum is AW bits wide, so it wraps
            rdata_b[k] = mem[raddr_b + AW'(k)];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `DMEM_BYTES; i++) begin
                mem[i] <= 8'(i + 3);              // Boot pattern
            end
        end else begin
            for (int k = 0; k < LANES; k++) begin
                if (wbe[k]) begin
                    mem[waddr + AW'(k)] <= wdata[8*k +: 8];
                end
            end
        end
    end

endmodule

// File: hw/commit_fifo.sv
`timescale 1ns/100ps
`include "dmem_consts.svh"

module commit_fifo import dmem_pkg::*; #(
    parameter type payload_t = commit_req_t
) (
    input  logic      clk,
    input  logic      reset,
    input  payload_t  in_data,
    input  logic      in_valid,
    output logic      in_ready,
    output payload_t  out_data,
    output logic      out_valid,
    input  logic      out_ready
);

    localparam int DEPTH = `CQ_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t          entries [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              push;
    logic              pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign in_ready  = (count != CNT_W'(DEPTH));  // Not full
    assign out_valid = (count != '0);             // Not empty
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;
    assign out_data  = entries[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                entries[i] <= '0;                 // Idle head reads as zero
            end
        end else begin
            if (push) begin
                entries[wr_ptr] <= in_data;
                wr_ptr          <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;          // Idle, or push and pop together
            endcase
        end
    end

endmodule

// File: hw/load_store_mem.sv
`timescale 1ns/100ps
`include "dmem_consts.svh"

module load_store_mem import dmem_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  load_req_t     load_req,
    output load_resp_t    load_resp,
    input  commit_req_t   head,        // Oldest retired memory op
    input  logic          head_valid,
    output logic          head_pop,
    output commit_resp_t  resp,        // Pushed on the pop edge
    input  logic          resp_space
);

    localparam int AW = `DMEM_AW;

    lanes_t                   spec_raw;
    lanes_t                   commit_raw;
    logic [`XLEN-1:0]         spec_data;
    logic [`XLEN-1:0]         commit_data;
    logic [`XLEN-1:0]         store_wdata;
    logic [`XLEN_BYTES-1:0]   store_wbe;
    logic [`XLEN_BYTES-1:0]   ram_wbe;
    logic                     do_store;
    logic                     mismatch;
    logic                     spec_valid_q;
    logic [`XLEN-1:0]         spec_data_q;

    // Port a serves speculative loads, port b the commit head
    byte_ram u_ram (
        .clk     (clk),
        .reset   (reset),
        .raddr_a (load_req.address[AW-1:0]),
        .raddr_b (head.address[AW-1:0]),
        .rdata_a (spec_raw),
        .rdata_b (commit_raw),
        .waddr   (head.address[AW-1:0]),
        .wdata   (store_wdata),
        .wbe     (ram_wbe)
    );

    mem_align u_load_align (
        .funct3     (load_req.funct3),
        .raw        (spec_raw),
        .store_data ('0),                     // Load only
        .load_data  (spec_data),
        .wbe        (),
        .wdata      ()
    );

    mem_align u_commit_align (
        .funct3     (head.funct3),
        .raw        (commit_raw),
        .store_data (head.value),
        .load_data  (commit_data),
        .wbe        (store_wbe),
        .wdata      (store_wdata)
    );

    // Retire only when the response has somewhere to go
    assign head_pop = head_valid && resp_space;
    assign do_store = head_pop && head.is_store;
    assign ram_wbe  = do_store ? store_wbe : '0;

    // Memory changed under a speculative load
    assign mismatch = !head.is_store && (commit_data != head.value);

    assign resp = '{is_store: head.is_store, exception: mismatch};

    always_ff @(posedge clk) begin
        if (reset) begin
            spec_valid_q <= 1'b0;
        end else begin
            spec_valid_q <= load_req.valid;       // Single-cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (load_req.valid) begin
            spec_data_q <= spec_data;
        end
    end

    assign load_resp = '{valid: spec_valid_q, data: spec_data_q};

endmodule

// File: hw/dmem_top.sv
`timescale 1ns/100ps

module dmem_top import dmem_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  load_req_t     load_req,
    output load_resp_t    load_resp,
    input  commit_req_t   commit_req,
    input  logic          commit_valid,
    output logic          commit_ready,
    output commit_resp_t  commit_resp,
    output logic          resp_valid,
    input  logic          resp_ready
);

    commit_req_t   req_head;
    logic          req_head_valid;
    logic          req_pop;
    commit_resp_t  resp_in;
    logic          resp_space;

    // Reorder buffer side request queue
    commit_fifo #(.payload_t(commit_req_t)) u_req_q (
        .clk       (clk),
        .reset     (reset),
        .in_data   (commit_req),
        .in_valid  (commit_valid),
        .in_ready  (commit_ready),
        .out_data  (req_head),
        .out_valid (req_head_valid),
        .out_ready (req_pop)
    );

    load_store_mem u_lsm (
        .clk        (clk),
        .reset      (reset),
        .load_req   (load_req),
        .load_resp  (load_resp),
        .head       (req_head),
        .head_valid (req_head_valid),
        .head_pop   (req_pop),
        .resp       (resp_in),
        .resp_space (resp_space)
    );

    // Responses wait here while the reorder buffer stalls
    commit_fifo #(.payload_t(commit_resp_t)) u_resp_q (
        .clk       (clk),
        .reset     (reset),
        .in_data   (resp_in),
        .in_valid  (req_pop),                 // One response per retired op
        .in_ready  (resp_space),
        .out_data  (commit_resp),
        .out_valid (resp_valid),
        .out_ready (resp_ready)
    );

endmodule

// File: verif/dmem_clkgen.sv
`timescale 1ns/100ps

module dmem_clkgen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    // Released on a falling edge, away from the sampling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// File: verif/dmem_chk.sv
`timescale 1ns/100ps

module dmem_chk import dmem_pkg::*; (
    input logic          clk,
    input logic          reset,
    input load_req_t     load_req,
    input load_resp_t    load_resp,
    input commit_req_t   commit_req,
    input logic          commit_valid,
    input logic          commit_ready,
    input commit_resp_t  commit_resp,
    input logic          resp_valid,
    input logic          resp_ready
);

    int unsigned fail_count = 0;
    int unsigned outstanding;                    // Accepted but not yet answered
    logic        req_fire;
    logic        resp_fire;

    assign req_fire  = commit_valid && commit_ready;
    assign resp_fire = resp_valid && resp_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            outstanding <= 0;
        end else if (req_fire && !resp_fire) begin
            outstanding <= outstanding + 1;
        end else if (!req_fire && resp_fire) begin
            outstanding <= outstanding - 1;
        end
    end

    a_load_pulse: assert property (@(posedge clk) disable iff (reset)
        load_req.valid |=> load_resp.valid)
        else begin
            $error("load_resp.valid missing one cycle after a load request");
            fail_count++;
        end

    a_no_stray_load: assert property (@(posedge clk) disable iff (reset)
        !load_req.valid |=> !load_resp.valid)
        else begin
            $error("load_resp.valid high without a load request");
            fail_count++;
        end

    a_req_stable: assert property (@(posedge clk) disable iff (reset)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit_req))
        else begin
            $error("commit request changed or dropped while stalled");
            fail_count++;
        end

    a_resp_has_req: assert property (@(posedge clk) disable iff (reset)
        resp_valid |-> outstanding != 0)
        else begin
            $error("commit response without an outstanding request");
            fail_count++;
        end

    // Idle outputs right after a reset edge
    a_reset_idle: assert property (@(posedge clk)
        reset |=> !load_resp.valid && !resp_valid && !commit_resp.exception && commit_ready)
        else begin
            $error("outputs not idle after reset");
            fail_count++;
        end

endmodule

bind dmem_top dmem_chk u_chk (
    .clk          (clk),
    .reset        (reset),
    .load_req     (load_req),
    .load_resp    (load_resp),
    .commit_req   (commit_req),
    .commit_valid (commit_valid),
    .commit_ready (commit_ready),
    .commit_resp  (commit_resp),
    .resp_valid   (resp_valid),
    .resp_ready   (resp_ready)
);

// File: verif/dmem_tb.sv
`timescale 1ns/100ps
`include "dmem_consts.svh"

module dmem_tb import dmem_pkg::*; ();

    localparam int N_OPS          = 600;
    localparam int TIMEOUT_CYCLES = 8 * N_OPS + 200;   // Room for the stall phase
    localparam int MASK           = `DMEM_BYTES - 1;
    localparam load_req_t NO_LOAD = '0;

    logic          clk;
    logic          reset;
    load_req_t     load_req;
    load_resp_t    load_resp;
    commit_req_t   commit_req;
    logic          commit_valid;
    logic          commit_ready;
    commit_resp_t  commit_resp;
    logic          resp_valid;
    logic          resp_ready;

    logic [7:0]    shadow [`DMEM_BYTES];      // Memory as the commit path sees it
    commit_req_t   push_q [$];
    commit_resp_t  exp_q [$];
    logic [31:0]   addrs [$];                 // Store targets for later loads
    logic          load_chk = 1'b0;
    logic [31:0]   load_exp;
    logic          req_fire = 1'b0;
    logic          saw_full = 1'b0;
    int            stall_pct = 0;
    int            cycles = 0;
    int            errs = 0;

    dmem_clkgen u_clkgen (.clk(clk), .reset(reset));

    dmem_top DUT (.*);

    // RISC-V load extension over four bytes from addr up
    function automatic logic [31:0] expect_load(input logic [2:0] f3, input logic [31:0] addr);
        logic [31:0] w;
        for (int k = 0; k < 4; k++) begin
            w[8*k +: 8] = shadow[(addr + k) & MASK];
        end
        case (f3)
            3'b000:  return {{24{w[7]}}, w[7:0]};
            3'b001:  return {{16{w[15]}}, w[15:0]};
            3'b010:  return w;
            3'b100:  return {24'h0, w[7:0]};
            3'b101:  return {16'h0, w[15:0]};
            default: return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] rand_addr();
        if ($urandom_range(5) == 0) begin
            return ($urandom() & ~32'(MASK)) | (MASK - $urandom_range(3));   // Wraps
        end
        return $urandom();
    endfunction

    function automatic mem_size_e rand_f3(input bit store);
        case ($urandom_range(store ? 7 : 10))
            0, 1:    return MEM_B;
            2, 3:    return MEM_H;
            4, 5:    return MEM_W;
            6:       return store ? MEM_HU : MEM_BU;   // No such store
            7:       return MEM_BU;
            8, 9:    return MEM_HU;
            default: return mem_size_e'(3'b011);
        endcase
    endfunction

    function automatic commit_req_t rand_commit(input bit store);
        commit_req_t r;
        r.is_store = store;
        r.funct3   = rand_f3(store);
        r.address  = rand_addr();
        if (addrs.size() != 0 && $urandom_range(1) != 0) begin
            r.address = addrs[$urandom_range(addrs.size() - 1)] + $urandom_range(3);
        end
        r.value = $urandom();
        if (!store) begin
            r.value = expect_load(r.funct3, r.address);
            if ($urandom_range(1) != 0) begin
                r.value = r.value ^ (32'h1 << $urandom_range(31));   // Stale value
            end
        end
        return r;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            errs++;
            $display("[ERROR] %0d ns: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    // Commit order is program order, so the shadow moves at queue time
    task automatic queue_commit(input commit_req_t r);
        int n;
        n = (r.funct3 == MEM_B) ? 1 : (r.funct3 == MEM_H) ? 2 : (r.funct3 == MEM_W) ? 4 : 0;
        if (r.is_store) begin
            for (int k = 0; k < n; k++) begin
                shadow[(r.address + k) & MASK] = r.value[8*k +: 8];
            end
            addrs.push_back(r.address);
            exp_q.push_back('{is_store: 1'b1, exception: 1'b0});
        end else begin
            exp_q.push_back('{is_store: 1'b0,
                              exception: r.value != expect_load(r.funct3, r.address)});
        end
        push_q.push_back(r);
    endtask

    // Sample outputs and drive inputs on one falling edge
    task automatic tick(input load_req_t lreq, input logic [31:0] lexp);
        commit_resp_t e;
        @(negedge clk);
        if (load_chk) begin
            check_eq("load_resp.valid", 32'd1, 32'(load_resp.valid));
            check_eq("load_resp.data", load_exp, load_resp.data);
        end
        if (req_fire) begin
            commit_valid = 1'b0;                 // Taken on the last rising edge
        end
        if (!commit_valid && push_q.size() != 0) begin
            commit_req   = push_q.pop_front();
            commit_valid = 1'b1;
        end
        load_req   = lreq;
        load_chk   = lreq.valid;
        load_exp   = lexp;
        resp_ready = $urandom_range(99) >= stall_pct;
        req_fire   = commit_valid && commit_ready;
        saw_full   = saw_full || !commit_ready;
        if (resp_valid && resp_ready) begin
            if (exp_q.size() == 0) begin
                errs++;
                $display("Commit response at %0d ns with no request outstanding", $time);
            end else begin
                e = exp_q.pop_front();
                check_eq("commit_resp.is_store", 32'(e.is_store), 32'(commit_resp.is_store));
                check_eq("commit_resp.exception", 32'(e.exception), 32'(commit_resp.exception));
            end
        end
    endtask

    task automatic spec_load(input mem_size_e f3, input logic [31:0] addr);
        tick('{valid: 1'b1, funct3: f3, address: addr}, expect_load(f3, addr));
    endtask

    task automatic drain();
        while (push_q.size() != 0 || commit_valid || exp_q.size() != 0) begin
            tick(NO_LOAD, 32'h0);
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with commit traffic still pending", cycles);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        commit_req_t r;
        logic [31:0] a;
        logic [31:0] old_v;
        void'($urandom(32'h29717c7d));
        load_req     = NO_LOAD;
        commit_req   = '0;
        commit_valid = 1'b0;
        resp_ready   = 1'b1;
        for (int i = 0; i < `DMEM_BYTES; i++) begin
            shadow[i] = 8'(i + 3);
        end
        wait (!reset);
        @(negedge clk);
        check_eq("commit_ready", 32'd1, 32'(commit_ready));
        check_eq("resp_valid", 32'd0, 32'(resp_valid));
        check_eq("load_resp.valid", 32'd0, 32'(load_resp.valid));

        repeat (40) spec_load(($urandom_range(1) != 0) ? MEM_W : MEM_BU, rand_addr());
        repeat (200) spec_load(rand_f3(1'b0), rand_addr());

        repeat (60) queue_commit(rand_commit(1'b1));
        drain();
        repeat (60) spec_load(rand_f3(1'b0), addrs[$urandom_range(addrs.size() - 1)] + 1);

        repeat (80) queue_commit(rand_commit($urandom_range(2) == 0));
        drain();

        // Stall the response side until the request queue backs up
        stall_pct = 100;
        saw_full  = 1'b0;
        repeat (12) queue_commit(rand_commit($urandom_range(1) != 0));
        repeat (14) tick(NO_LOAD, 32'h0);
        assert (saw_full) else begin
            errs++;
            $display("commit_ready never fell while responses were stalled");
        end
        stall_pct = 50;
        repeat (100) queue_commit(rand_commit($urandom_range(1) != 0));
        drain();
        stall_pct = 0;

        repeat (10) begin
            a     = rand_addr();
            r     = '{is_store: 1'b1, funct3: MEM_W, address: a, value: $urandom()};
            old_v = expect_load(MEM_W, a);
            queue_commit(r);
            tick(NO_LOAD, 32'h0);                                  // Store enters the queue
            tick('{valid: 1'b1, funct3: MEM_W, address: a}, old_v); // Same edge as the write
            spec_load(MEM_W, a);
            drain();
        end
        tick(NO_LOAD, 32'h0);

        $display("Errors: %0d in data checks, %0d in assertions", errs, DUT.u_chk.fail_count);
        if (errs == 0 && DUT.u_chk.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
hw/dmem_pkg.sv
hw/mem_align.sv
hw/byte_ram.sv
hw/commit_fifo.sv
hw/load_store_mem.sv
hw/dmem_top.sv
verif/dmem_clkgen.sv
verif/dmem_chk.sv
verif/dmem_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= dmem_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= sim passed
SOURCES   := $(wildcard hw/*.sv verif/*.sv include/*.svh)

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status comes from the search for the pass line
run: compile
	@out="$$(./$(SIM_BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
